/* tlu_params.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TLU handshake parameters
// widths, clock divisor and fixed wait counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TLU_PARAMS_SVH
`define TLU_PARAMS_SVH

// trigger clock samples per TLU clock period
`define TLU_DIVISOR 8

// FIFO word, counter and trigger number width
`define TLU_WORD_W 32

`define TLU_TIMEOUT_W 8 // wait-for-low counter
`define TLU_BITCNT_W 5  // clock_cycles setting
`define TLU_DELAY_W 4   // extra latch delay setting

// most serial bits per trigger, also what clock_cycles = 0 selects
`define TLU_MAX_BITS 32

// short scintillator pulses can glitch the TLU trigger line,
// so never look at trigger low before this many cycles
`define TLU_GLITCH_WAIT 5

// synchronizer stages between TLU data line and shift register
`define TLU_SYNC_DELAY 3

`endif

/* tlu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TLU handshake types
// modes, FSM states, config and status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tlu_params.svh"

package tlu_pkg;

    typedef logic [`TLU_WORD_W-1:0]    tlu_word_t;
    typedef logic [`TLU_TIMEOUT_W-1:0] timeout_t;
    typedef logic [`TLU_BITCNT_W-1:0]  bit_count_t;
    typedef logic [`TLU_DELAY_W-1:0]   delay_t;
    typedef logic [`TLU_BITCNT_W:0]    bit_total_t; // 1..32 serial bits

    typedef enum logic [1:0] {
        TRG_ONLY       = 2'd0,
        FLAG_HANDSHAKE = 2'd1,
        LOW_HANDSHAKE  = 2'd2,
        DATA_HANDSHAKE = 2'd3
    } tlu_mode_t;

    typedef enum logic [2:0] {
        IDLE              = 3'd0,
        WAIT_TRIGGER_LOW  = 3'd1,
        SEND_TLU_CLOCK    = 3'd2,
        WAIT_BEFORE_LATCH = 3'd3,
        LATCH_DATA        = 3'd4,
        WAIT_ACKNOWLEDGE  = 3'd5
    } fsm_state_t;

    typedef struct packed {
        tlu_mode_t  mode;
        timeout_t   low_time_out; // 0 disables the timeout
        bit_count_t clock_cycles; // 0 means 32
        delay_t     data_delay;
        logic       msb_first;
    } tlu_cfg_t;

    typedef struct packed {
        logic busy;
        logic clock_enable;
        logic low_timeout_error;
    } tlu_status_t;

    // number of serial bits the TLU sends per trigger
    function automatic bit_total_t bits_per_trigger(input bit_count_t clock_cycles);
        bits_per_trigger = (clock_cycles == '0) ? bit_total_t'(`TLU_MAX_BITS)
                                                : {1'b0, clock_cycles};
    endfunction

endpackage

/* tlu_handshake_fsm.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TLU trigger handshake FSM
// acceptance, TLU clocking, latch timing and acknowledge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "tlu_params.svh"

module tlu_handshake_fsm
    import tlu_pkg::*;
#(
    parameter int divisor = `TLU_DIVISOR
) (
    input  logic        trigger_clk,
    input  logic        reset,
    input  logic        tlu_reset_flag,
    input  logic        trigger,
    input  logic        trigger_flag,
    input  logic        trigger_veto,
    input  logic        trigger_enable,
    input  logic        trigger_acknowledge,
    input  tlu_cfg_t    cfg,
    output logic        accept_pulse,
    output logic        latch_strobe,
    output logic        fifo_write,
    output tlu_status_t status
);

    localparam int CLK_CNT_W = $clog2(`TLU_MAX_BITS * divisor + 1);

    fsm_state_t state;
    fsm_state_t next_state;

    timeout_t              low_cnt;     // cycles spent waiting for trigger low
    logic [CLK_CNT_W-1:0]  clk_cnt;     // TLU clock phase
    logic [CLK_CNT_W-1:0]  clk_target;
    logic [4:0]            wait_cnt;    // delay before latching serial data
    logic [4:0]            wait_target;
    bit_total_t            n_bits;

    logic busy_q;
    logic clk_en_q;
    logic timeout_err_q;
    logic acknowledged;

    logic flag_ok;
    logic line_ok;
    logic accept_ok;
    logic ack_seen;
    logic low_done;
    logic timeout_hit;

    assign n_bits      = bits_per_trigger(cfg.clock_cycles);
    assign clk_target  = CLK_CNT_W'(n_bits) * CLK_CNT_W'(divisor);
    assign wait_target = 5'(cfg.data_delay) + 5'(`TLU_SYNC_DELAY);

    // veto only blocks the internal strobe, a TLU line trigger ignores it
    assign flag_ok   = trigger_flag && !trigger_veto;
    assign line_ok   = trigger && (cfg.mode == LOW_HANDSHAKE || cfg.mode == DATA_HANDSHAKE);
    assign accept_ok = !trigger_acknowledge && trigger_enable && (flag_ok || line_ok);

    assign ack_seen = trigger_acknowledge || acknowledged;

    // glitch wait over and line low, or gave up on it
    assign low_done = (!trigger || timeout_err_q)
                      && (low_cnt >= timeout_t'(`TLU_GLITCH_WAIT));

    assign timeout_hit = (cfg.low_time_out != '0) && (low_cnt >= cfg.low_time_out);

    always_ff @(posedge trigger_clk)
    begin
        if (reset || tlu_reset_flag)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (accept_ok)
                    next_state = WAIT_TRIGGER_LOW;
            end
            WAIT_TRIGGER_LOW:
            begin
                if (cfg.mode == TRG_ONLY || cfg.mode == FLAG_HANDSHAKE)
                    next_state = LATCH_DATA;    // no TLU line to watch
                else if (low_done && cfg.mode == DATA_HANDSHAKE)
                    next_state = SEND_TLU_CLOCK;
                else if (low_done)
                    next_state = LATCH_DATA;
            end
            SEND_TLU_CLOCK:
            begin
                if (clk_cnt == clk_target)
                    next_state = WAIT_BEFORE_LATCH;
            end
            WAIT_BEFORE_LATCH:
            begin
                if (wait_cnt == wait_target)
                    next_state = LATCH_DATA;
            end
            LATCH_DATA, WAIT_ACKNOWLEDGE:
            begin
                // an early acknowledge lets busy drop right after the write
                next_state = ack_seen ? IDLE : WAIT_ACKNOWLEDGE;
            end
            default:
            begin
                next_state = IDLE;
            end
        endcase
    end

    // receiver takes its sample on the edge entering LATCH_DATA
    assign latch_strobe = (next_state == LATCH_DATA);

    // outputs registered from next state
    always_ff @(posedge trigger_clk)
    begin
        if (reset || tlu_reset_flag)
        begin
            accept_pulse  <= 1'b0;
            fifo_write    <= 1'b0;
            busy_q        <= 1'b0;
            clk_en_q      <= 1'b0;
            timeout_err_q <= 1'b0;
            acknowledged  <= 1'b0;
            low_cnt       <= '0;
            clk_cnt       <= '0;
            wait_cnt      <= '0;
        end
        else
        begin
            accept_pulse <= (state == IDLE) && (next_state == WAIT_TRIGGER_LOW);
            fifo_write   <= latch_strobe;
            busy_q       <= (next_state != IDLE);
            clk_en_q     <= (next_state == SEND_TLU_CLOCK);

            if (next_state != WAIT_TRIGGER_LOW)
                low_cnt <= '0;
            else if (low_cnt != '1)
                low_cnt <= low_cnt + 1'b1;  // saturate, error must not wrap away

            clk_cnt  <= (next_state == SEND_TLU_CLOCK) ? clk_cnt + 1'b1 : '0;
            wait_cnt <= (next_state == WAIT_BEFORE_LATCH) ? wait_cnt + 1'b1 : '0;

            if (next_state == IDLE)
                timeout_err_q <= 1'b0;
            else if (next_state == WAIT_TRIGGER_LOW && timeout_hit)
                timeout_err_q <= 1'b1;      // sticky until idle

            if (next_state == IDLE)
                acknowledged <= 1'b0;
            else if (trigger_acknowledge)
                acknowledged <= 1'b1;
        end
    end

    assign status.busy              = busy_q;
    assign status.clock_enable      = clk_en_q;
    assign status.low_timeout_error = timeout_err_q;

endmodule

/* tlu_serial_receiver.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TLU serial trigger number receiver
// oversampled shift register and bit-order latch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "tlu_params.svh"

module tlu_serial_receiver
    import tlu_pkg::*;
#(
    parameter int divisor = `TLU_DIVISOR
) (
    input  logic      trigger_clk,
    input  logic      trigger,
    input  logic      latch_strobe,
    input  tlu_cfg_t  cfg,
    output tlu_word_t trigger_number
);

    localparam int SR_W = `TLU_MAX_BITS * divisor;

    logic [SR_W-1:0] data_sr;   // newest sample at bit 0
    bit_total_t      n_bits;
    tlu_word_t       sampled;

    assign n_bits = bits_per_trigger(cfg.clock_cycles);

    // free running at one sample per trigger clock
    always_ff @(posedge trigger_clk)
    begin
        data_sr <= {data_sr[SR_W-2:0], trigger};
    end

    // slot k (counted back from the last bit sent) spans
    // data_sr[k*divisor +: divisor] and gives its top sample
    always_comb
    begin
        int slot;

        slot    = 0;
        sampled = '0;
        for (int n = 0; n < `TLU_MAX_BITS; n++)
        begin
            if (n < int'(n_bits) - 1)           // bit N-1 and above stay zero
            begin
                if (cfg.msb_first)
                    slot = n;                   // last bit sent is bit 0
                else
                    slot = int'(n_bits) - 1 - n; // first bit sent is bit 0
                sampled[n] = data_sr[slot * divisor + divisor - 1];
            end
        end
    end

    // held until the next trigger's latch
    always_ff @(posedge trigger_clk)
    begin
        if (latch_strobe)
            trigger_number <= sampled;
    end

endmodule

/* tlu_event_recorder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Trigger counter and FIFO word assembly
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "tlu_params.svh"

module tlu_event_recorder
    import tlu_pkg::*;
(
    input  logic      trigger_clk,
    input  logic      reset,
    input  logic      accept_pulse,
    input  logic      counter_set,
    input  tlu_word_t counter_set_value,
    input  tlu_word_t trigger_number,
    input  tlu_mode_t mode,
    output tlu_word_t fifo_data
);

    tlu_word_t trigger_count;
    tlu_word_t count_at_accept;    // value before this trigger's increment
    tlu_word_t payload;

    // preset from host wins over the increment
    always_ff @(posedge trigger_clk)
    begin
        if (reset)
            trigger_count <= '0;
        else if (counter_set)
            trigger_count <= counter_set_value;
        else if (accept_pulse)
            trigger_count <= trigger_count + 1'b1;
    end

    always_ff @(posedge trigger_clk)
    begin
        if (accept_pulse)
            count_at_accept <= trigger_count;
    end

    // TLU number only when it was clocked out of the TLU
    always_comb
    begin
        if (mode == DATA_HANDSHAKE)
            payload = trigger_number;
        else
            payload = count_at_accept;
    end

    assign fifo_data = {1'b1, payload[`TLU_WORD_W-2:0]}; // top bit tags a trigger word

endmodule

/* tlu_controller.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TLU trigger handshake controller top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "tlu_params.svh"

module tlu_controller
    import tlu_pkg::*;
(
    input  logic        trigger_clk,
    input  logic        reset,
    input  logic        trigger,             // TLU line, serial data in mode 3
    input  logic        trigger_flag,
    input  logic        trigger_veto,
    input  logic        trigger_enable,
    input  logic        trigger_acknowledge,
    input  logic        tlu_reset_flag,
    input  tlu_cfg_t    cfg,
    input  logic        counter_set,
    input  tlu_word_t   counter_set_value,
    output logic        fifo_write,
    output tlu_word_t   fifo_data,
    output logic        trigger_accepted_flag,
    output tlu_status_t status
);

    logic      latch_strobe;
    tlu_word_t trigger_number;

    tlu_handshake_fsm #(
        .divisor             (`TLU_DIVISOR)
    ) u_fsm (
        .trigger_clk         (trigger_clk),
        .reset               (reset),
        .tlu_reset_flag      (tlu_reset_flag),
        .trigger             (trigger),
        .trigger_flag        (trigger_flag),
        .trigger_veto        (trigger_veto),
        .trigger_enable      (trigger_enable),
        .trigger_acknowledge (trigger_acknowledge),
        .cfg                 (cfg),
        .accept_pulse        (trigger_accepted_flag),
        .latch_strobe        (latch_strobe),
        .fifo_write          (fifo_write),
        .status              (status)
    );

    tlu_serial_receiver #(
        .divisor        (`TLU_DIVISOR)
    ) u_receiver (
        .trigger_clk    (trigger_clk),
        .trigger        (trigger),
        .latch_strobe   (latch_strobe),
        .cfg            (cfg),
        .trigger_number (trigger_number)
    );

    tlu_event_recorder u_recorder (
        .trigger_clk       (trigger_clk),
        .reset             (reset),
        .accept_pulse      (trigger_accepted_flag),
        .counter_set       (counter_set),
        .counter_set_value (counter_set_value),
        .trigger_number    (trigger_number),
        .mode              (cfg.mode),
        .fifo_data         (fifo_data)
    );

endmodule

/* tb_tlu_controller.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TLU controller testbench
// TLU emulator, host model and reference counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "tlu_params.svh"

module tb_tlu_controller
    import tlu_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int DIV = `TLU_DIVISOR;

    typedef struct packed {
        logic [1:0]  mode;
        logic [4:0]  cc;
        logic        msb;
        logic [3:0]  dd;
        logic [7:0]  lto;
        logic [31:0] tnum;
        logic [7:0]  hold;
        logic [7:0]  ack;
        logic        pset;
        logic [31:0] pval;
        logic [1:0]  kind;  // 0 trigger, 1 vetoed flag, 2 tlu reset mid-sequence
    } stim_event_t;

    logic trigger_clk, reset, trigger, trigger_flag, trigger_veto, trigger_enable;
    logic trigger_acknowledge, tlu_reset_flag, counter_set;
    tlu_cfg_t    cfg;
    tlu_word_t   counter_set_value;
    logic        fifo_write, trigger_accepted_flag;
    tlu_word_t   fifo_data;
    tlu_status_t status;

    stim_event_t events[$];
    tlu_word_t   ref_count;
    logic [31:0] lfsr_state = 32'h1359b53e;
    int          num_events = 0;

    tlu_controller uut (.*);

    initial
    begin
        trigger_clk = 1'b0;
        forever #(CLK_PERIOD / 2) trigger_clk = ~trigger_clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32,22,2,1
    endfunction

    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    function automatic int bit_count(input stim_event_t ev);
        return (ev.cc == 5'd0) ? `TLU_MAX_BITS : int'(ev.cc);
    endfunction

    // trigger number with bit N-1 and above cleared
    function automatic tlu_word_t expected_number(input stim_event_t ev);
        logic [63:0] mask;
        mask = (64'd1 << (bit_count(ev) - 1)) - 64'd1;
        return ev.tnum & mask[31:0];
    endfunction

    // internal strobe plus a second strobe while busy when the host is slow
    task automatic drive_flag(input stim_event_t ev);
        trigger_flag = 1'b1;
        @(negedge trigger_clk);
        trigger_flag = 1'b0;
        if (ev.ack >= 8'd6)
        begin
            repeat (2) @(negedge trigger_clk);
            trigger_flag = 1'b1;
            @(negedge trigger_clk);
            trigger_flag = 1'b0;
        end
    endtask

    // TLU line high for hold cycles then serial number in mode 3
    task automatic drive_tlu(input stim_event_t ev);
        int n;
        n = bit_count(ev);
        trigger = 1'b1;
        for (int k = 0; k < int'(ev.hold); k++)
        begin
            @(negedge trigger_clk);
            if (fifo_write)
                break;  // timed out so release the line before idle
        end
        trigger = 1'b0;
        if (ev.mode == 2'd3 && ev.kind != 2'd2)
        begin
            while (!status.clock_enable)
                @(negedge trigger_clk);
            repeat (int'(ev.dd) + `TLU_SYNC_DELAY - 1) @(negedge trigger_clk);
            for (int i = 0; i < n; i++)
            begin
                trigger = ev.msb ? ev.tnum[n - 1 - i] : ev.tnum[i];
                repeat (DIV) @(negedge trigger_clk);
            end
            trigger = 1'b0;
        end
    endtask

    task automatic host_ack(input stim_event_t ev);
        while (!trigger_accepted_flag)
            @(negedge trigger_clk);
        repeat (int'(ev.ack)) @(negedge trigger_clk);
        trigger_acknowledge = 1'b1;
        do
            @(negedge trigger_clk);
        while (status.busy);
        trigger_acknowledge = 1'b0;
    endtask

    // samples at posedge see the values of the cycle that just ended
    task automatic watch_event(input stim_event_t ev, input tlu_word_t exp_word);
        int c = 0, acc_c = -1, wr_c = -1, idle_c = -1, n_acc = 0, ce_cnt = 0;
        bit ack_any = 0, to_seen = 0;
        forever
        begin
            @(posedge trigger_clk);
            c++;
            if (trigger_accepted_flag)
            begin
                n_acc++;
                if (acc_c < 0)
                    acc_c = c;
            end
            if (acc_c < 0)
                continue;
            if (c == idle_c)
            begin
                check_equal(32'(status.busy), 32'd0, "busy after acknowledge");
                break;
            end
            check_equal(32'(status.busy), 32'd1, "busy before acknowledge");
            ack_any |= trigger_acknowledge;
            ce_cnt += int'(status.clock_enable);
            to_seen |= status.low_timeout_error;
            if (fifo_write)
            begin
                wr_c = c;
                check_equal(fifo_data, exp_word, "fifo word");
            end
            if (wr_c >= 0 && ack_any && idle_c < 0)
                idle_c = c + 1;
        end
        check_equal(32'(n_acc), 32'd1, "accepted triggers in one sequence");
        if (ev.mode < 2'd2)
            check_equal(32'(wr_c - acc_c), 32'd1, "fifo_write delay after accept");
        check_equal(32'(ce_cnt), (ev.mode == 2'd3) ? 32'(bit_count(ev) * DIV) : 32'd0,
                    "clock_enable cycles");
        check_equal(32'(to_seen), 32'(ev.lto != 8'd0 && ev.lto < ev.hold), "low timeout error");
    endtask

    task automatic run_event(input stim_event_t ev);
        tlu_word_t exp_word;
        int gap;
        cfg.mode         = tlu_mode_t'(ev.mode);
        cfg.clock_cycles = ev.cc;
        cfg.msb_first    = ev.msb;
        cfg.data_delay   = ev.dd;
        cfg.low_time_out = ev.lto;
        random_bits(4, gap);
        repeat (gap + 2) @(negedge trigger_clk);
        if (ev.pset)
        begin
            counter_set = 1'b1;
            counter_set_value = ev.pval;
            @(negedge trigger_clk);
            counter_set = 1'b0;
            ref_count = ev.pval;
        end
        if (ev.kind == 2'd1)
        begin
            trigger_veto = 1'b1;
            trigger_flag = 1'b1;
            @(negedge trigger_clk);
            trigger_flag = 1'b0;
            trigger_veto = 1'b0;
            repeat (10)
            begin
                @(posedge trigger_clk);
                check_equal(32'(trigger_accepted_flag | fifo_write | status.busy), 32'd0,
                            "vetoed flag accepted");
            end
            @(negedge trigger_clk);
        end
        else if (ev.kind == 2'd2)
        begin
            drive_tlu(ev);
            while (!status.clock_enable)
                @(negedge trigger_clk);
            repeat (4) @(negedge trigger_clk);
            tlu_reset_flag = 1'b1;
            @(negedge trigger_clk);
            tlu_reset_flag = 1'b0;
            check_equal(32'({status.busy, status.clock_enable}), 32'd0, "state after tlu reset");
            ref_count++;    // the trigger was counted before the abort
        end
        else
        begin
            exp_word = (ev.mode == 2'd3) ? expected_number(ev) : ref_count;
            exp_word[31] = 1'b1;
            ref_count++;
            fork
                if (ev.mode < 2'd2)
                    drive_flag(ev);
                else
                    drive_tlu(ev);
                host_ack(ev);
                watch_event(ev, exp_word);
            join
            @(negedge trigger_clk);
        end
    endtask

    initial
    begin
        int fd, rc, m, cc, msb, dd, lto, hold, ack, ps, kind;
        logic [31:0] tnum, pv;
        string line;
        stim_event_t ev;

        reset = 1'b1;
        {trigger, trigger_flag, trigger_veto, trigger_acknowledge} = '0;
        {tlu_reset_flag, counter_set} = '0;
        trigger_enable = 1'b1;
        counter_set_value = '0;
        cfg = '0;
        ref_count = '0;

        fd = $fopen("tlu_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file tlu_stimulus.txt");
            $display(">>> FAIL");
            $fatal(1);
        end
        while (!$feof(fd))
        begin
            rc = $fgets(line, fd);
            if (rc == 0 || line.len() == 0 || line.getc(0) == "#")
                continue;
            rc = $sscanf(line, "%d %d %d %d %d %h %d %d %d %h %d",
                         m, cc, msb, dd, lto, tnum, hold, ack, ps, pv, kind);
            if (rc != 11)
                continue;
            ev = {m[1:0], cc[4:0], msb[0], dd[3:0], lto[7:0], tnum, hold[7:0], ack[7:0],
                  ps[0], pv, kind[1:0]};
            events.push_back(ev);
        end
        $fclose(fd);
        num_events = events.size();

        repeat (5) @(posedge trigger_clk);
        @(negedge trigger_clk);
        check_equal(32'({fifo_write, trigger_accepted_flag, status}), 32'd0, "outputs in reset");
        reset = 1'b0;

        foreach (events[i])
            run_event(events[i]);

        $display(">>> PASS");
        $finish;
    end

    // budget per event covers the longest serial readout plus gaps and host delay
    initial
    begin
        wait (num_events > 0);
        repeat (num_events * (`TLU_MAX_BITS * DIV + 300) + 10) @(posedge trigger_clk);
        $display("simulation timed out waiting for fifo_write");
        $display(">>> FAIL");
        $fatal(1);
    end

endmodule

/* tlu_stimulus.txt */
# mode clock_cycles msb_first data_delay low_time_out trigger_number(hex)
# hold ack_delay preset preset_value(hex) kind (0 trigger, 1 vetoed flag, 2 tlu reset)
0 0 0 0 0 00000000 0 3 0 00000000 0
1 0 0 0 0 00000000 0 8 0 00000000 0
0 0 0 0 0 00000000 0 1 0 00000000 1
0 0 0 0 0 00000000 0 0 1 00001000 0
1 0 0 0 0 00000000 0 6 0 00000000 0
1 0 0 0 0 00000000 0 2 0 00000000 1
0 0 0 0 0 00000000 0 4 0 00000000 0
2 0 0 0 20 00000000 3 12 0 00000000 0
2 0 0 0 10 00000000 30 40 0 00000000 0
2 0 0 0 0 00000000 40 5 0 00000000 0
2 0 0 0 8 00000000 6 9 0 00000000 0
3 8 0 0 0 000000a5 2 4 0 00000000 0
3 8 1 0 0 000000a5 2 1 0 00000000 0
3 16 1 2 0 0000c3e7 1 30 0 00000000 0
3 0 0 5 0 ffffffff 3 2 0 00000000 0
3 0 1 15 40 8badf00d 4 1 0 00000000 0
3 5 0 1 0 00000013 2 0 0 00000000 0
3 31 1 7 0 5a5a5a5a 2 3 0 00000000 0
3 16 0 2 0 00001234 2 0 0 00000000 2
0 0 0 0 0 00000000 0 3 0 00000000 0
0 0 0 0 0 00000000 0 2 1 7ffffffe 0
1 0 0 0 0 00000000 0 7 0 00000000 0
0 0 0 0 0 00000000 0 3 0 00000000 0

/* sim.f */
+incdir+.
tlu_pkg.sv
tlu_handshake_fsm.sv
tlu_serial_receiver.sv
tlu_event_recorder.sv
tlu_controller.sv
tb_tlu_controller.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_tlu_controller
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
